/* Bender.yml */
package:
  name: cdd_link

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/cdd_pkg.sv
      - src/cdd_byte_if.sv
      - src/cdd_status_latch.sv
      - src/cdd_frame_buffer.sv
      - src/cdd_serial_port.sv
      - src/cdd_link.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/cdd_link_tb.sv

/* flist.f */
+incdir+include
src/cdd_pkg.sv
src/cdd_byte_if.sv
src/cdd_status_latch.sv
src/cdd_frame_buffer.sv
src/cdd_serial_port.sv
src/cdd_link.sv
test/cdd_link_tb.sv

/* include/cdd_params.svh */
////////////////////////////////////////////////////////////
// wait and gap counts are in clk_sys cycles
// the byte gap must be at least 2 and the slot count at least 2
////////////////////////////////////////////////////////////
`ifndef CDD_PARAMS_SVH
`define CDD_PARAMS_SVH

// bytes in one status or command frame
`define CDD_FRAME_BYTES 12

// delay from capturing a new status frame to offering it
`define CDD_START_WAIT 15

// delay from the last bit of a byte to the next request
`define CDD_BYTE_GAP 1023

// frames held between the latch and the serial port
`define CDD_FRAME_SLOTS 2

`endif

/* src/cdd_byte_if.sv */
////////////////////////////////////////////////////////////
// four-phase byte handoff, data and last valid while req is high
////////////////////////////////////////////////////////////
`default_nettype none

interface cdd_byte_if
	import cdd_pkg::*;
();

	logic      req;
	logic      ack;
	cdd_byte_t data;
	// high on the final byte of a frame
	logic      last;

	modport sender (
		output req,
		output data,
		output last,
		input  ack
	);

	modport receiver (
		input  req,
		input  data,
		input  last,
		output ack
	);

endinterface

`default_nettype wire

/* src/cdd_frame_buffer.sv */
////////////////////////////////////////////////////////////
// ring of CDD_FRAME_SLOTS frames, a slot frees after its last byte
////////////////////////////////////////////////////////////
`default_nettype none

`include "cdd_params.svh"

module cdd_frame_buffer
	import cdd_pkg::*;
(
	input  wire        clk_sys,
	input  wire        reset,
	input  wire        frame_req,
	input  wire        cdd_frame_t frame_data,
	output logic       frame_ack,
	cdd_byte_if.sender byte_out
);

	localparam int SLOTS = `CDD_FRAME_SLOTS;
	localparam int PTR_W = $clog2(SLOTS);
	localparam int CNT_W = $clog2(SLOTS + 1);

	cdd_frame_t       slot_mem [SLOTS];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_next;
	cdd_index_t       byte_idx;
	logic             byte_req;
	logic             wait_release;
	logic             push;
	logic             pop;
	logic             last_byte;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(SLOTS - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign push       = frame_req && !frame_ack && (count != CNT_W'(SLOTS));
	assign last_byte  = (byte_idx == cdd_index_t'(`CDD_FRAME_BYTES - 1));
	// slot is released once the last byte's ack has gone low
	assign pop        = wait_release && !byte_out.ack && last_byte;
	assign count_next = count + CNT_W'(push) - CNT_W'(pop);

	////////////////////////////////////////////////////////////
	// write side
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			frame_ack <= 1'b0;
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
		end else begin
			count <= count_next;
			if (push) begin
				frame_ack <= 1'b1;
				wr_ptr    <= ptr_inc(wr_ptr);
			end else if (frame_ack && !frame_req) begin
				frame_ack <= 1'b0;
			end
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (push)
			slot_mem[wr_ptr] <= frame_data;
	end

	////////////////////////////////////////////////////////////
	// read side, one byte per handshake
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			byte_req     <= 1'b0;
			wait_release <= 1'b0;
			byte_idx     <= '0;
		end else if (byte_req) begin
			if (byte_out.ack) begin
				byte_req     <= 1'b0;
				wait_release <= 1'b1;
			end
		end else if (wait_release) begin
			if (!byte_out.ack) begin
				wait_release <= 1'b0;
				if (last_byte) begin
					byte_idx <= '0;
					byte_req <= (count_next != '0);
				end else begin
					byte_idx <= byte_idx + 4'd1;
					byte_req <= 1'b1;
				end
			end
		end else if (count != '0) begin
			byte_req <= 1'b1;
		end
	end

	assign byte_out.req  = byte_req;
	assign byte_out.last = last_byte;
	assign byte_out.data = slot_mem[rd_ptr][byte_idx * 8 +: 8];

	// a write never lands on the slot being read out
	a_no_overfill: assert property (@(posedge clk_sys) disable iff (reset)
		push |-> (count == '0) || (wr_ptr != rd_ptr));

	a_req_held: assert property (@(posedge clk_sys) disable iff (reset)
		(byte_out.req && !byte_out.ack) |=> byte_out.req);

endmodule

`default_nettype wire

/* src/cdd_link.sv */
////////////////////////////////////////////////////////////
// drive-side link, status in and command frames out
////////////////////////////////////////////////////////////
`default_nettype none

module cdd_link
	import cdd_pkg::*;
(
	input  wire        clk_sys,
	input  wire        reset,
	input  wire        cdd_frame_t stat_frame,
	input  wire        stat_toggle,
	input  wire        comclk,
	input  wire        hdata,
	output logic       cdata,
	output logic       comreq_n,
	output logic       comsync_n,
	output cdd_frame_t comm_frame,
	output logic       comm_toggle
);

	logic       frame_req;
	logic       frame_ack;
	cdd_frame_t frame_data;

	cdd_byte_if byte_bus ();

	// new status frames from the host
	cdd_status_latch u_latch (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.stat_frame  (stat_frame),
		.stat_toggle (stat_toggle),
		.frame_req   (frame_req),
		.frame_data  (frame_data),
		.frame_ack   (frame_ack)
	);

	cdd_frame_buffer u_buffer (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.frame_req  (frame_req),
		.frame_data (frame_data),
		.frame_ack  (frame_ack),
		.byte_out   (byte_bus.sender)
	);

	// three-wire link to the host
	cdd_serial_port u_port (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.byte_in     (byte_bus.receiver),
		.comclk      (comclk),
		.hdata       (hdata),
		.cdata       (cdata),
		.comreq_n    (comreq_n),
		.comsync_n   (comsync_n),
		.comm_frame  (comm_frame),
		.comm_toggle (comm_toggle)
	);

endmodule

`default_nettype wire

/* src/cdd_pkg.sv */
////////////////////////////////////////////////////////////
// frame width follows CDD_FRAME_BYTES from the params header
////////////////////////////////////////////////////////////
`default_nettype none

`include "cdd_params.svh"

package cdd_pkg;

	// one byte on the drive link
	typedef logic [7:0] cdd_byte_t;

	// whole frame, byte 0 in bits 7..0
	typedef logic [8*`CDD_FRAME_BYTES-1:0] cdd_frame_t;

	// byte position inside a frame
	typedef logic [3:0] cdd_index_t;

endpackage

`default_nettype wire

/* src/cdd_serial_port.sv */
////////////////////////////////////////////////////////////
// comclk idles high, the host clocks 8 bits per comreq_n
// edges outside a byte transfer are ignored
////////////////////////////////////////////////////////////
`default_nettype none

`include "cdd_params.svh"

module cdd_serial_port
	import cdd_pkg::*;
(
	input  wire          clk_sys,
	input  wire          reset,
	cdd_byte_if.receiver byte_in,
	input  wire          comclk,
	input  wire          hdata,
	output logic         cdata,
	output logic         comreq_n,
	output logic         comsync_n,
	output cdd_frame_t   comm_frame,
	output logic         comm_toggle
);

	localparam int GAP_W = $clog2(`CDD_BYTE_GAP + 1);

	typedef enum logic [1:0] {SP_WAIT, SP_START, SP_XFER} port_state_t;

	port_state_t      state;
	logic [1:0]       comclk_sync;
	logic             comclk_prev;
	logic [1:0]       hdata_sync;
	logic             bit_rise;
	logic             bit_fall;
	logic             byte_end;
	logic             accept;
	logic             byte_ack;
	logic [GAP_W-1:0] gap_cnt;
	logic [2:0]       bit_cnt;
	cdd_index_t       byte_idx;
	logic             first_pend;
	logic             cur_last;
	logic             frame_done;
	cdd_byte_t        st_shift;
	cdd_byte_t        cmd_shift;
	cdd_byte_t        cmd_byte;

	////////////////////////////////////////////////////////////
	// host clock and data synchronizers
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			comclk_sync <= 2'b11;
			comclk_prev <= 1'b1;
		end else begin
			comclk_sync <= {comclk_sync[0], comclk};
			comclk_prev <= comclk_sync[1];
		end
	end

	// same depth as comclk so hdata lines up with the rising edge
	always_ff @(posedge clk_sys) begin
		hdata_sync <= {hdata_sync[0], hdata};
	end

	assign bit_rise = (state == SP_XFER) && comclk_sync[1] && !comclk_prev;
	assign bit_fall = (state == SP_XFER) && !comclk_sync[1] && comclk_prev;
	assign byte_end = bit_rise && (bit_cnt == 3'd7);
	assign accept   = (state == SP_WAIT) && (gap_cnt == '0) && byte_in.req && !byte_ack;
	assign cmd_byte = {hdata_sync[1], cmd_shift[7:1]};

	////////////////////////////////////////////////////////////
	// byte sequencing
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state       <= SP_WAIT;
			gap_cnt     <= '0;
			byte_ack    <= 1'b0;
			comreq_n    <= 1'b1;
			comsync_n   <= 1'b1;
			cdata       <= 1'b0;
			bit_cnt     <= '0;
			byte_idx    <= '0;
			first_pend  <= 1'b1;
			cur_last    <= 1'b0;
			frame_done  <= 1'b0;
			comm_toggle <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (frame_done)
				comm_toggle <= ~comm_toggle;
			if (byte_ack && !byte_in.req)
				byte_ack <= 1'b0;
			case (state)
				SP_WAIT: begin
					if (gap_cnt != '0) begin
						gap_cnt <= gap_cnt - 1'b1;
					end else if (accept) begin
						byte_ack <= 1'b1;
						cur_last <= byte_in.last;
						bit_cnt  <= '0;
						byte_idx <= first_pend ? '0 : byte_idx + 4'd1;
						state    <= SP_START;
					end
				end
				SP_START: begin
					comreq_n  <= 1'b0;
					comsync_n <= !first_pend;
					state     <= SP_XFER;
				end
				default: begin
					if (bit_fall)
						cdata <= st_shift[0];
					if (bit_rise) begin
						comreq_n <= 1'b1;
						bit_cnt  <= bit_cnt + 3'd1;
					end
					if (byte_end) begin
						comsync_n  <= 1'b1;
						first_pend <= cur_last;
						frame_done <= cur_last;
						gap_cnt    <= GAP_W'(`CDD_BYTE_GAP - 2);
						state      <= SP_WAIT;
					end
				end
			endcase
		end
	end

	// shift registers and the collected command frame
	always_ff @(posedge clk_sys) begin
		if (accept)
			st_shift <= byte_in.data;
		else if (bit_fall)
			st_shift <= st_shift >> 1;
		if (bit_rise)
			cmd_shift <= cmd_byte;
		if (byte_end)
			comm_frame[byte_idx * 8 +: 8] <= cmd_byte;
	end

	assign byte_in.ack = byte_ack;

	// sync only while byte 0 of a frame is on the link
	a_sync_with_req: assert property (@(posedge clk_sys) disable iff (reset)
		!comsync_n |-> (state == SP_XFER) && (byte_idx == '0));

endmodule

`default_nettype wire

/* src/cdd_status_latch.sv */
////////////////////////////////////////////////////////////
// toggles seen while a frame is still pending are dropped
////////////////////////////////////////////////////////////
`default_nettype none

`include "cdd_params.svh"

module cdd_status_latch
	import cdd_pkg::*;
(
	input  wire        clk_sys,
	input  wire        reset,
	input  wire        cdd_frame_t stat_frame,
	input  wire        stat_toggle,
	output logic       frame_req,
	output cdd_frame_t frame_data,
	input  wire        frame_ack
);

	localparam int WAIT_W = $clog2(`CDD_START_WAIT + 1);

	typedef enum logic [1:0] {L_IDLE, L_WAIT, L_OFFER, L_RELEASE} latch_state_t;

	latch_state_t      state;
	logic              toggle_last;
	logic [WAIT_W-1:0] wait_cnt;
	logic              new_frame;

	assign new_frame = (stat_toggle != toggle_last) && (state == L_IDLE);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state       <= L_IDLE;
			toggle_last <= 1'b0;
			wait_cnt    <= '0;
			frame_req   <= 1'b0;
		end else begin
			toggle_last <= stat_toggle;
			case (state)
				L_IDLE: begin
					if (new_frame) begin
						wait_cnt <= WAIT_W'(`CDD_START_WAIT - 1);
						state    <= L_WAIT;
					end
				end
				L_WAIT: begin
					if (wait_cnt == '0) begin
						frame_req <= 1'b1;
						state     <= L_OFFER;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				// buffer full keeps ack low, so we sit here
				L_OFFER: begin
					if (frame_ack) begin
						frame_req <= 1'b0;
						state     <= L_RELEASE;
					end
				end
				default: begin
					if (!frame_ack)
						state <= L_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (new_frame)
			frame_data <= stat_frame;
	end

	a_data_held: assert property (@(posedge clk_sys) disable iff (reset)
		frame_req |=> (!frame_req || $stable(frame_data)));

endmodule

`default_nettype wire

/* test/cdd_link_tb.sv */
////////////////////////////////////////////////////////////
// vectors come from test/cdd_testdata.txt, run from the project root
////////////////////////////////////////////////////////////
`default_nettype none

`include "cdd_params.svh"

module cdd_link_tb
	import cdd_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int REQ_TIMEOUT    = `CDD_BYTE_GAP + `CDD_START_WAIT + 100;
	localparam int TOGGLE_TIMEOUT = 16;

	logic       clk_sys;
	logic       reset;
	cdd_frame_t stat_frame;
	logic       stat_toggle;
	logic       comclk;
	logic       hdata;
	logic       cdata;
	logic       comreq_n;
	logic       comsync_n;
	cdd_frame_t comm_frame;
	logic       comm_toggle;

	string      name_q [$];
	cdd_frame_t stat_q [$];
	cdd_frame_t cmd_q [$];

	cdd_link DUT (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.stat_frame  (stat_frame),
		.stat_toggle (stat_toggle),
		.comclk      (comclk),
		.hdata       (hdata),
		.cdata       (cdata),
		.comreq_n    (comreq_n),
		.comsync_n   (comsync_n),
		.comm_frame  (comm_frame),
		.comm_toggle (comm_toggle)
	);

	always #20 clk_sys = ~clk_sys;

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////
	// all drives and samples happen 2 ns after the rising edge
	task automatic tick();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic compare_value(input string test, input string what,
			input logic [95:0] exp, input logic [95:0] act);
		assert (act === exp) else
			report_failure($sformatf("mismatch %0s %0s expected %0h actual %0h",
				test, what, exp, act));
	endtask

	task automatic load_vectors();
		int         fd;
		int         n;
		string      tok;
		string      rest;
		cdd_frame_t st;
		cdd_frame_t cm;
		fd = $fopen("test/cdd_testdata.txt", "r");
		assert (fd != 0) else report_failure("could not open the test data file");
		while (!$feof(fd)) begin
			n = $fscanf(fd, "%s", tok);
			if (n == 1) begin
				if (tok.getc(0) == "#") begin
					n = $fgets(rest, fd);
				end else begin
					n = $fscanf(fd, "%h %h", st, cm);
					assert (n == 2) else report_failure({"bad vector line for test ", tok});
					name_q.push_back(tok);
					stat_q.push_back(st);
					cmd_q.push_back(cm);
				end
			end
		end
		$fclose(fd);
		assert (stat_q.size() != 0) else report_failure("the test data file holds no vectors");
	endtask

	// new status frame, marked by a toggle
	task automatic post_status(input cdd_frame_t frame);
		stat_frame  = frame;
		stat_toggle = ~stat_toggle;
	endtask

	////////////////////////////////////////////////////////////
	// host side of the drive link
	////////////////////////////////////////////////////////////
	task automatic wait_request(input string test);
		int cnt;
		cnt = 0;
		while (comreq_n && cnt < REQ_TIMEOUT) begin
			tick();
			cnt++;
		end
		assert (!comreq_n) else report_failure({"comreq_n never went low in test ", test});
	endtask

	task automatic transfer_byte(input string test, input int idx,
			input cdd_byte_t exp_stat, input cdd_byte_t cmd);
		int        half;
		cdd_byte_t got;
		wait_request(test);
		compare_value(test, "comsync_n at request", (idx == 0) ? 1'b0 : 1'b1, comsync_n);
		for (int i = 0; i < 8; i++) begin
			comclk = 1'b0;
			hdata  = cmd[i];
			half   = 2 + ($urandom % 5);
			repeat (half) tick();
			comclk = 1'b1;
			half   = 2 + ($urandom % 5);
			repeat (half) tick();
			got[i] = cdata;
			if (i == 3)
				compare_value(test, "comsync_n mid byte", (idx == 0) ? 1'b0 : 1'b1, comsync_n);
		end
		compare_value(test, $sformatf("status byte %0d", idx), exp_stat, got);
	endtask

	// one whole frame, posting the next n_post status frames after its first bytes
	task automatic run_frame(input int v, input int n_post);
		logic toggle_prev;
		int   cnt;
		toggle_prev = comm_toggle;
		for (int b = 0; b < `CDD_FRAME_BYTES; b++) begin
			transfer_byte(name_q[v], b, stat_q[v][b*8 +: 8], cmd_q[v][b*8 +: 8]);
			if (b < n_post)
				post_status(stat_q[v + 1 + b]);
			if (b < `CDD_FRAME_BYTES - 1)
				compare_value(name_q[v], "comm_toggle before last byte", toggle_prev, comm_toggle);
		end
		cnt = 0;
		while (comm_toggle == toggle_prev && cnt < TOGGLE_TIMEOUT) begin
			tick();
			cnt++;
		end
		assert (comm_toggle != toggle_prev) else
			report_failure({"comm_toggle did not flip after the frame in test ", name_q[v]});
		compare_value(name_q[v], "comm_frame", cmd_q[v], comm_frame);
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////
	initial begin
		int v;
		int n_post;
		clk_sys     = 1'b0;
		reset       = 1'b1;
		stat_frame  = '0;
		stat_toggle = 1'b0;
		comclk      = 1'b1;
		hdata       = 1'b0;
		void'($urandom(32'h5609_8fb3));
		load_vectors();
		repeat (4) tick();
		reset = 1'b0;

		compare_value("reset", "comreq_n", 1'b1, comreq_n);
		compare_value("reset", "comsync_n", 1'b1, comsync_n);
		compare_value("reset", "cdata", 1'b0, cdata);
		compare_value("reset", "comm_toggle", 1'b0, comm_toggle);
		// no status toggle, so no request
		repeat (2000) begin
			tick();
			assert (comreq_n) else report_failure("comreq_n fell with no status frame posted");
		end

		// groups of frames, the rest of a group posted while its first frame is on the link
		// so the buffer fills up and the last one stalls in the latch
		v = 0;
		while (v < stat_q.size()) begin
			n_post = stat_q.size() - v - 1;
			if (n_post > `CDD_FRAME_SLOTS)
				n_post = `CDD_FRAME_SLOTS;
			post_status(stat_q[v]);
			run_frame(v, n_post);
			for (int k = 1; k <= n_post; k++)
				run_frame(v + k, 0);
			v += n_post + 1;
		end

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* test/cdd_testdata.txt */
# columns: test name, status frame, host command frame
# frames are 24 hex digits, byte 0 is the rightmost pair
seq_bytes  0b0a09080706050403020100 1c1b1a191817161514131211
all_ones   ffffffffffffffffffffffff 000000000000000000000000
alt_bits   55aa55aa55aa55aa55aa55aa aa55aa55aa55aa55aa55aa55
walk_one   804020100804020180402010 010204081020408001020408
mixed      00c1a3c0f1e20123456789ab 5a5a0000123400ff0f0f1e2d
zero_stat  000000000000000000000000 3c3c3c3c9669966987654321
